// ==== hdl/starfield_defines.svh ====
`ifndef STARFIELD_DEFINES_SVH
`define STARFIELD_DEFINES_SVH

// video timing, small values for simulation
`define STAR_H_TOTAL   288 // pixels per line
`define STAR_HS_START  272 // first hdump with hs high
`define STAR_HS_END    280 // first hdump with hs low again
`define STAR_V_TOTAL   20  // lines per frame
`define STAR_VB_START  16  // vb high from here to the last line
`define STAR_CEN_DIV   2   // clocks per pixel enable

// one star word per 32-pixel column group
`define STAR_CACHE_DEPTH 16

// star rom port
`define STAR_ADDR_W 13
`define STAR_DATA_W 32

`endif

// ==== hdl/starfield_pkg.sv ====
package starfield_pkg;

    // one byte of the star rom, as cached per column group
    typedef struct packed {
        logic [2:0] pal_id; // palette, bit 2 picks the blink counter
        logic [4:0] pos;    // x offset inside the 32-pixel group
    } star_entry_t;

    // line fetch sequencing
    typedef enum logic [1:0] {
        IDLE = 2'd0, // waiting for hs to fall
        REQ  = 2'd1, // wishbone reads in progress
        DONE = 2'd2  // one cycle after the last ack
    } fetch_state_t;

    // pixel handed to the layer mixer
    typedef struct packed {
        logic [2:0] pal;   // palette
        logic [3:0] color; // 15 is transparent
    } star_pxl_t;

endpackage

// ==== hdl/video_timer.sv ====
`timescale 1ns/1ps
`include "starfield_defines.svh"

module video_timer (
    input  logic       clk,
    input  logic       rst,
    output logic       pxl_cen,
    output logic       hs,
    output logic       vb,
    output logic [8:0] hdump,
    output logic [8:0] vdump
);

    localparam int CEN_W = $clog2(`STAR_CEN_DIV);

    logic [CEN_W-1:0] cen_cnt;
    logic [8:0]       h_next;
    logic [8:0]       v_next;
    logic             h_wrap;

    // clock divider for the pixel enable
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_cnt <= '0;
            pxl_cen <= 1'b0;
        end else begin
            if (cen_cnt == CEN_W'(`STAR_CEN_DIV - 1)) begin
                cen_cnt <= '0;
            end else begin
                cen_cnt <= cen_cnt + 1'b1;
            end
            pxl_cen <= cen_cnt == CEN_W'(`STAR_CEN_DIV - 1); // one clk in DIV
        end
    end

    // next position, decoded ahead so hs/vb line up with the counters
    always_comb begin
        h_wrap = hdump == 9'(`STAR_H_TOTAL - 1);
        h_next = h_wrap ? 9'd0 : hdump + 9'd1;
        v_next = vdump;
        if (h_wrap) begin
            // line end
            v_next = (vdump == 9'(`STAR_V_TOTAL - 1)) ? 9'd0 : vdump + 9'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump <= '0;
            vdump <= '0;
            hs    <= 1'b0;
            vb    <= 1'b0;
        end else if (pxl_cen) begin
            hdump <= h_next;
            vdump <= v_next;
            hs    <= h_next >= 9'(`STAR_HS_START) && h_next < 9'(`STAR_HS_END);
            vb    <= v_next >= 9'(`STAR_VB_START); // last lines of the frame
        end
    end

endmodule

// ==== hdl/star_fetch_fsm.sv ====
`timescale 1ns/1ps
`include "starfield_defines.svh"

module star_fetch_fsm (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      hs,
    input  logic [8:0]                vdump,
    input  logic [8:0]                hpos,
    input  logic [8:0]                vpos,
    input  logic                      flip,
    input  logic                      wb_ack,
    input  logic [`STAR_DATA_W-1:0]   wb_dat,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic [`STAR_ADDR_W-1:0]   wb_adr,
    output logic                      cache_we,
    output logic [3:0]                cache_wr_idx,
    output starfield_pkg::star_entry_t cache_wr_data
);

    starfield_pkg::fetch_state_t state;

    logic       hs_l;     // hs one clk ago
    logic       hs_fall;
    logic [3:0] idx;      // column group being fetched
    logic [8:0] veff;     // effective line, held for the whole fetch
    logic [3:0] col_sum;
    logic [3:0] rom_hpos;

    assign hs_fall = hs_l & ~hs;

    // rom column for group idx, modulo 16 on purpose
    always_comb begin
        col_sum  = ~hpos[8:5] + idx + 4'd2;
        rom_hpos = ~(col_sum ^ {4{flip}});
    end

    // classic cycle, held steady until ack
    assign wb_cyc = state == starfield_pkg::REQ;
    assign wb_stb = state == starfield_pkg::REQ;
    assign wb_adr = {rom_hpos, veff};

    assign cache_we      = wb_cyc & wb_ack;
    assign cache_wr_idx  = idx;
    assign cache_wr_data = starfield_pkg::star_entry_t'(wb_dat[7:0]); // low byte only

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= starfield_pkg::IDLE;
            hs_l  <= 1'b0;
            idx   <= '0;
            veff  <= '0;
        end else begin
            hs_l <= hs;
            case (state)
                starfield_pkg::IDLE: begin
                    if (hs_fall) begin // hs while busy is dropped
                        state <= starfield_pkg::REQ;
                        idx   <= '0;
                        veff  <= (vpos + vdump) ^ {9{flip}};
                    end
                end
                starfield_pkg::REQ: begin
                    if (wb_ack) begin
                        if (idx == 4'(`STAR_CACHE_DEPTH - 1)) begin
                            state <= starfield_pkg::DONE; // 16th word in
                        end else begin
                            idx <= idx + 4'd1;
                        end
                    end
                end
                starfield_pkg::DONE: state <= starfield_pkg::IDLE;
                default:             state <= starfield_pkg::IDLE;
            endcase
        end
    end

endmodule

// ==== hdl/star_line_cache.sv ====
`timescale 1ns/1ps
`include "starfield_defines.svh"

module star_line_cache (
    input  logic                       clk,
    input  logic                       we,
    input  logic [3:0]                 wr_idx,
    input  starfield_pkg::star_entry_t wr_data,
    input  logic [3:0]                 rd_idx,
    output starfield_pkg::star_entry_t rd_data
);

    // one word per column group of the coming line
    starfield_pkg::star_entry_t mem [`STAR_CACHE_DEPTH];

    // write port, from the fetch
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // read port, one clk behind the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_idx];
    end

endmodule

// ==== hdl/star_pixel.sv ====
`timescale 1ns/1ps

module star_pixel (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pxl_cen,
    input  logic                       vb,
    input  logic [8:0]                 hdump,
    input  logic [8:0]                 hpos,
    input  logic                       flip,
    input  starfield_pkg::star_entry_t rd_data,
    output logic [3:0]                 rd_idx,
    output starfield_pkg::star_pxl_t   pxl
);

    logic [8:0]                 heff;
    logic [4:0]                 hlo_q;  // heff[4:0] of the previous enable
    starfield_pkg::star_entry_t star_q; // cache word of the previous enable
    logic [4:0]                 p;
    logic                       lit;
    logic                       vb_l;
    logic [3:0]                 fcnt;
    logic [3:0]                 cnt15;
    logic [3:0]                 cnt16;

    // scrolled, flipped x position
    assign heff   = (hpos + hdump) ^ {9{flip}};
    assign rd_idx = heff[8:5]; // column group

    always_comb begin
        p   = star_q.pos ^ {5{flip}};
        lit = p == hlo_q && p != 5'd15; // 15 means empty group
    end

    // first pipeline stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hlo_q  <= '0;
            star_q <= '0;
        end else if (pxl_cen) begin
            hlo_q  <= heff[4:0];
            star_q <= rd_data;
        end
    end

    // frame count and blink
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vb_l  <= 1'b0;
            fcnt  <= '0;
            cnt15 <= '0;
            cnt16 <= '0;
        end else if (pxl_cen) begin
            vb_l <= vb;
            if (vb && !vb_l) begin
                fcnt <= fcnt + 4'd1;
                if (fcnt == 4'd15) begin
                    // every 16 frames
                    cnt15 <= (cnt15 == 4'd14) ? 4'd0 : cnt15 + 4'd1; // never transparent
                    cnt16 <= cnt16 + 4'd1; // reaches 15, star blanks
                end
            end
        end
    end

    // output pixel, second stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl.pal   <= 3'd0;
            pxl.color <= 4'd15;
        end else if (pxl_cen) begin
            pxl.pal <= star_q.pal_id;
            if (lit) begin
                pxl.color <= star_q.pal_id[2] ? cnt15 : cnt16;
            end else begin
                pxl.color <= 4'd15;
            end
        end
    end

endmodule

// ==== hdl/starfield_top.sv ====
`timescale 1ns/1ps
`include "starfield_defines.svh"

module starfield_top (
    input  logic                     clk,
    input  logic                     rst,
    // scroll and flip registers
    input  logic [8:0]               hpos,
    input  logic [8:0]               vpos,
    input  logic                     flip,
    // star rom, wishbone classic master
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic [`STAR_ADDR_W-1:0]  wb_adr,
    input  logic                     wb_ack,
    input  logic [`STAR_DATA_W-1:0]  wb_dat,
    // video
    output logic                     pxl_cen,
    output logic                     hs,
    output logic                     vb,
    output logic [8:0]               hdump,
    output logic [8:0]               vdump,
    output starfield_pkg::star_pxl_t pxl
);

    logic                       cache_we;
    logic [3:0]                 cache_wr_idx;
    starfield_pkg::star_entry_t cache_wr_data;
    logic [3:0]                 rd_idx;
    starfield_pkg::star_entry_t rd_data;

    video_timer u_timer (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .hs      (hs),
        .vb      (vb),
        .hdump   (hdump),
        .vdump   (vdump)
    );

    // fills the cache during horizontal blank
    star_fetch_fsm u_fetch (
        .clk           (clk),
        .rst           (rst),
        .hs            (hs),
        .vdump         (vdump),
        .hpos          (hpos),
        .vpos          (vpos),
        .flip          (flip),
        .wb_ack        (wb_ack),
        .wb_dat        (wb_dat),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_adr        (wb_adr),
        .cache_we      (cache_we),
        .cache_wr_idx  (cache_wr_idx),
        .cache_wr_data (cache_wr_data)
    );

    star_line_cache u_cache (
        .clk     (clk),
        .we      (cache_we),
        .wr_idx  (cache_wr_idx),
        .wr_data (cache_wr_data),
        .rd_idx  (rd_idx),
        .rd_data (rd_data)
    );

    star_pixel u_pixel (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .vb      (vb),
        .hdump   (hdump),
        .hpos    (hpos),
        .flip    (flip),
        .rd_data (rd_data),
        .rd_idx  (rd_idx),
        .pxl     (pxl)
    );

endmodule

// ==== sim/starfield_checker.sv ====
`timescale 1ns/1ps
`include "starfield_defines.svh"

module starfield_checker (
    input logic                     clk,
    input logic                     rst,
    input logic                     wb_cyc,
    input logic                     wb_stb,
    input logic                     wb_ack,
    input logic [`STAR_ADDR_W-1:0]  wb_adr,
    input starfield_pkg::star_pxl_t pxl,
    input logic [3:0]               cnt15, // blink counters inside u_pixel
    input logic [3:0]               cnt16
);

    stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else $error("wb_stb high outside a bus cycle");

    // classic handshake, address held until ack
    adr_held: assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack |=> $stable(wb_adr))
        else $error("wb_adr moved before ack");

    cyc_after_reset: assert property (@(posedge clk) $fell(rst) |-> !wb_cyc)
        else $error("wb_cyc high right after reset");

    // pixel holds two clks, counter may step at the same enable
    color_from_counter: assert property (@(posedge clk) disable iff (rst)
        pxl.color != 4'd15 |->
            pxl.color == (pxl.pal[2] ? cnt15 : cnt16) ||
            pxl.color == (pxl.pal[2] ? $past(cnt15, 2) : $past(cnt16, 2)))
        else $error("lit pixel colour not from its blink counter");

endmodule

bind starfield_top starfield_checker u_checker (
    .clk    (clk),
    .rst    (rst),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .wb_adr (wb_adr),
    .pxl    (pxl),
    .cnt15  (u_pixel.cnt15),
    .cnt16  (u_pixel.cnt16)
);

// ==== sim/starfield_tb.sv ====
`timescale 1ns/1ps
`include "starfield_defines.svh"

module starfield_tb;

    localparam int FRAME_CLKS  = `STAR_H_TOTAL * `STAR_V_TOTAL * `STAR_CEN_DIV;
    localparam int PHASE_WORDS = 7; // hpos vpos flip frames wait cnt15 cnt16

    logic                     clk;
    logic                     rst;
    logic [8:0]               hpos;
    logic [8:0]               vpos;
    logic                     flip;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic [`STAR_ADDR_W-1:0]  wb_adr;
    logic                     wb_ack;
    logic [`STAR_DATA_W-1:0]  wb_dat;
    logic                     pxl_cen;
    logic                     hs;
    logic                     vb;
    logic [8:0]               hdump;
    logic [8:0]               vdump;
    starfield_pkg::star_pxl_t pxl;

    logic [7:0]                 rom [8192];       // star rom image
    logic [15:0]                phase_mem [43];   // count word, then 6 phases
    starfield_pkg::star_entry_t exp_cache [16];   // words of the fetch in flight
    starfield_pkg::star_entry_t model_cache [16]; // words of the last finished fetch
    logic [8:0]                 exp_veff;
    logic [8:0]                 h_hist [3];       // hdump of the last three enables
    logic [3:0]                 vb_hist;
    logic                       hs_q, cyc_q, cen_q, vb_q;
    logic                       busy, fetch_fresh, cache_valid;
    logic                       cen_m;            // expected pxl_cen
    int ack_cnt, wait_cnt, ack_wait, quiet_clks, samples;
    int vb_rises, fcnt, m15, m16, checked_px, lit_px;
    int lit_hi, lit_lo;                           // lit stars per blink counter
    int mh, mv, div_cnt;                          // expected video position
    int base, frames, exp15, exp16, start, limit, clks;

    starfield_top u_dut (
        .clk (clk), .rst (rst), .hpos (hpos), .vpos (vpos), .flip (flip),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_adr (wb_adr), .wb_ack (wb_ack),
        .wb_dat (wb_dat), .pxl_cen (pxl_cen), .hs (hs), .vb (vb),
        .hdump (hdump), .vdump (vdump), .pxl (pxl)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic fill_rom();
        logic [15:0] s;
        logic [7:0]  b;
        s = 16'd40;
        b = '0;
        for (int a = 0; a < 8192; a++) begin
            for (int k = 0; k < 8; k++) begin
                s = lfsr_step(s); // one step per bit
                b = {b[6:0], s[0]};
            end
            rom[a] = b;
        end
    endtask

    // rom address of column group i for the line veff
    function automatic logic [12:0] fetch_addr(input logic [3:0] i, input logic [8:0] hp,
                                               input logic fl, input logic [8:0] ve);
        logic [3:0] col;
        col = ~hp[8:5] + i + 4'd2;
        return {~(col ^ {4{fl}}), ve};
    endfunction

    // rom slave, ack after ack_wait idle cycles
    task automatic drive_rom();
        logic [12:0] want;
        if (wb_ack) begin
            wb_ack = 1'b0; // read taken at the last edge
        end else if (wb_stb) begin
            if (wait_cnt < ack_wait) begin
                wait_cnt++;
            end else begin
                wait_cnt = 0;
                assert (ack_cnt < 16) else abort_run("more than 16 reads in one line fetch");
                want = fetch_addr(4'(ack_cnt), hpos, flip, exp_veff);
                check_value("wb_adr", 32'(wb_adr), 32'(want));
                exp_cache[ack_cnt] = starfield_pkg::star_entry_t'(rom[wb_adr]);
                wb_dat = {24'ha5c3e1, rom[wb_adr]}; // upper bytes are ignored
                wb_ack = 1'b1;
                ack_cnt++;
            end
        end
    endtask

    // video timer reference, one call per clk
    task automatic check_timing();
        if (cen_m) begin
            mh = (mh + 1) % `STAR_H_TOTAL;
            if (mh == 0) begin
                mv = (mv + 1) % `STAR_V_TOTAL; // line wrap
            end
        end
        div_cnt = (div_cnt + 1) % `STAR_CEN_DIV;
        cen_m   = div_cnt == 0; // one clk in DIV
        check_value("pxl_cen", 32'(pxl_cen), 32'(cen_m));
        check_value("hdump", 32'(hdump), 32'(mh));
        check_value("vdump", 32'(vdump), 32'(mv));
        check_value("hs", 32'(hs), 32'(mh >= `STAR_HS_START && mh < `STAR_HS_END));
        check_value("vb", 32'(vb), 32'(mv >= `STAR_VB_START));
    endtask

    task automatic watch_fetch();
        if (hs_q && !hs && !busy) begin
            busy        = 1'b1; // fetch starts next clk
            fetch_fresh = 1'b1;
            ack_cnt     = 0;
            exp_veff    = (vpos + vdump) ^ {9{flip}};
        end
        assert (!wb_cyc || busy) else abort_run("wb_cyc rose without a falling hs edge");
        if (cyc_q && !wb_cyc) begin
            check_value("ack count", 32'(ack_cnt), 32'd16);
            for (int i = 0; i < 16; i++) begin
                model_cache[i] = exp_cache[i];
            end
            busy        = 1'b0;
            cache_valid = fetch_fresh; // stale if the registers moved mid fetch
        end
        quiet_clks = wb_cyc ? 0 : quiet_clks + 1;
        hs_q       = hs;
        cyc_q      = wb_cyc;
    endtask

    // reference pixel for the hdump two enables back
    task automatic watch_video();
        starfield_pkg::star_entry_t e;
        logic [8:0] heff;
        logic [4:0] p;
        logic       lit;
        logic [3:0] want;
        if (cen_q) begin
            h_hist[2] = h_hist[1];
            h_hist[1] = h_hist[0];
            h_hist[0] = hdump;
            vb_hist   = {vb_hist[2:0], vb};
            samples++;
            if (vb && !vb_q) begin
                vb_rises++;
                if (fcnt == 15) begin
                    m15 = (m15 + 1) % 15;
                    m16 = (m16 + 1) % 16;
                end
                fcnt = (fcnt + 1) % 16;
            end
            vb_q = vb;
            if (cache_valid && quiet_clks >= 8 && vb_hist == 4'd0 && samples >= 3) begin
                heff = (hpos + h_hist[2]) ^ {9{flip}};
                e    = model_cache[heff[8:5]];
                p    = e.pos ^ {5{flip}};
                lit  = (p == heff[4:0]) && (p != 5'd15);
                want = lit ? (e.pal_id[2] ? 4'(m15) : 4'(m16)) : 4'd15;
                check_value("pxl.pal", 32'(pxl.pal), 32'(e.pal_id));
                check_value("pxl.color", 32'(pxl.color), 32'(want));
                checked_px++;
                if (lit) lit_px++;
                if (lit && e.pal_id[2]) begin
                    lit_hi++; // shows cnt15
                end else if (lit) begin
                    lit_lo++; // shows cnt16
                end
            end
        end
        cen_q = pxl_cen;
    endtask

    task automatic tick();
        @(negedge clk);
        check_timing();
        watch_fetch();
        watch_video();
        drive_rom();
    endtask

    initial begin
        rst  = 1'b1;
        hpos = '0;
        vpos = '0;
        flip = 1'b0;
        wb_ack = 1'b0;
        wb_dat = '0;
        {hs_q, cyc_q, cen_q, vb_q, busy, fetch_fresh, cache_valid, cen_m} = '0;
        vb_hist = '0;
        for (int i = 0; i < 3; i++) h_hist[i] = '0;
        {ack_cnt, wait_cnt, ack_wait, quiet_clks, samples, mh, mv, div_cnt} = '0;
        {vb_rises, fcnt, m15, m16, checked_px, lit_px, lit_hi, lit_lo} = '0;
        exp_veff = '0;
        fill_rom();
        $readmemh("sim/starfield_input.txt", phase_mem);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("pxl.pal", 32'(pxl.pal), 32'd0);
        check_value("pxl.color", 32'(pxl.color), 32'd15);
        check_value("wb_cyc", 32'(wb_cyc), 32'd0);
        check_value("wb_stb", 32'(wb_stb), 32'd0);
        check_value("hs", 32'(hs), 32'd0);
        check_value("vb", 32'(vb), 32'd0);
        for (int ph = 0; ph < int'(phase_mem[0]); ph++) begin
            clks = 0;
            while (busy) begin // new registers only while the bus is idle
                tick();
                clks++;
                assert (clks < FRAME_CLKS)
                    else abort_run("timeout waiting for a line fetch to end");
            end
            base        = 1 + ph * PHASE_WORDS;
            hpos        = phase_mem[base][8:0];
            vpos        = phase_mem[base + 1][8:0];
            flip        = phase_mem[base + 2][0];
            frames      = int'(phase_mem[base + 3]);
            ack_wait    = int'(phase_mem[base + 4]);
            exp15       = int'(phase_mem[base + 5]);
            exp16       = int'(phase_mem[base + 6]);
            cache_valid = 1'b0; // wait for a fetch with the new registers
            fetch_fresh = 1'b0;
            checked_px  = 0;
            lit_px      = 0;
            start       = vb_rises;
            limit       = (frames + 2) * FRAME_CLKS;
            clks        = 0;
            while (vb_rises - start < frames) begin
                tick();
                clks++;
                assert (clks < limit) else abort_run("timeout waiting for the frames of a phase");
            end
            check_value("cnt15", 32'(m15), 32'(exp15));
            check_value("cnt16", 32'(m16), 32'(exp16));
            assert (checked_px > 0) else abort_run("no pixel was checked in a phase");
            assert (lit_px > 0) else abort_run("no lit star was seen in a phase");
            // the new blink values have to reach the screen
            lit_hi = 0;
            lit_lo = 0;
            clks   = 0;
            while (lit_hi == 0 || lit_lo == 0) begin
                tick();
                clks++;
                assert (clks < FRAME_CLKS && vb_rises - start == frames)
                    else abort_run("no lit star of each blink counter after the phase frames");
            end
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== sim/starfield_input.txt ====
// first word: number of phases, all values hex
// per phase: hpos vpos flip frames ack_wait cnt15 cnt16 (counters at phase end)
6
000 000 0 02 0 0 0
02b 015 0 14 0 1 1
11a 0c3 1 12 0 2 2
007 1f0 0 14 3 3 3
190 055 1 b4 1 0 f
0a0 002 0 10 5 1 0

// ==== starfield.f ====
+incdir+hdl
hdl/starfield_pkg.sv
hdl/video_timer.sv
hdl/star_fetch_fsm.sv
hdl/star_line_cache.sv
hdl/star_pixel.sv
hdl/starfield_top.sv
sim/starfield_checker.sv
sim/starfield_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module starfield_tb \
		-f starfield.f -Mdir obj_dir -o sim_starfield

run: compile
	-./obj_dir/sim_starfield > run.log 2>&1
	cat run.log
	grep -q "TEST PASS" run.log

clean:
	rm -rf obj_dir run.log
